// ==== compile.f ====
hw/alu_pkg.sv
hw/mux8.sv
hw/conv_unit.sv
hw/addsub_unit.sv
hw/logic_unit.sv
hw/alu_core.sv
verification/alu_core_assert.sv
verification/alu_core_tb.sv

// ==== hw/addsub_unit.sv ====
`timescale 1ns/10ps

/*
 * Add and subtract unit
 * ADD, ADC, SUB, SBB and CMP with full flag generation
 */
module addsub_unit
  import alu_pkg::*;
(
  input  logic [2:0]  func,
  input  logic [15:0] a,
  input  logic [15:0] b,
  input  logic        cfi,  // Carry or borrow in, from the flag register
  output alu_res_t    res
);

  logic        is_sub;    // SUB, SBB and CMP
  logic        is_valid;  // Code names a real operation
  logic        carry_in;
  logic [15:0] b_eff;     // Operand as seen by the adder, for overflow
  logic [16:0] sum;       // Bit 16 is carry out, or borrow for subtract
  logic [15:0] r;
  logic        half;
  logic        ovf;

  // ========================================
  // Decode
  // ========================================

  assign is_sub   = (func == SUB) | (func == SBB) | (func == CMP);
  assign is_valid = (func <= CMP);

  // Only the chained forms look at CF
  assign carry_in = ((func == ADC) | (func == SBB)) & cfi;

  // ========================================
  // Datapath
  // ========================================

  always_comb begin
    if (is_sub) begin
      sum = {1'b0, a} - {1'b0, b} - {16'h0000, carry_in}; // Wraps to set bit 16 on borrow
    end else begin
      sum = {1'b0, a} + {1'b0, b} + {16'h0000, carry_in};
    end
  end

  assign r     = sum[15:0];
  assign b_eff = is_sub ? ~b : b;

  // Carry or borrow into bit 4 shows as a mismatch of the operand bits there
  assign half = a[4] ^ b[4] ^ r[4];

  // Operands of equal sign giving a result of the other sign
  assign ovf = (a[15] == b_eff[15]) & (r[15] != a[15]);

  always_comb begin
    res = '0;
    if (is_valid) begin
      res.data     = {16'h0000, r}; // CMP hands back the difference as well
      res.flags    = szp_flags(r);
      res.flags.cf = sum[16];
      res.flags.af = half;
      res.flags.of = ovf;
      res.flags_we = FLAGS_WE_ALL;
    end
  end

endmodule

// ==== hw/alu_core.sv ====
`timescale 1ns/10ps

/*
 * ALU core
 * Runs the three units in parallel, registers the chosen result and keeps the flags
 */
module alu_core
  import alu_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       op_valid,   // One operation per strobe, no handshake
  input  alu_req_t   req,
  input  logic       flags_wr,   // Direct load of the flag register
  input  alu_flags_t flags_in,
  output logic       res_valid,
  output alu_res_t   res,
  output alu_flags_t flags       // The flag register itself
);

  alu_res_t   conv_res;
  alu_res_t   arith_res;
  alu_res_t   logic_res;
  alu_res_t   sel_res;     // Result of the addressed unit, still combinational
  alu_flags_t flags_next;  // Flag register after the current operation

  // ========================================
  // Execution units
  // ========================================

  // All units see the same request and run side by side
  conv_unit u_conv_unit (
    .func (req.func),
    .x    (req.a),
    .afi  (flags.af),
    .cfi  (flags.cf),
    .res  (conv_res)
  );

  addsub_unit u_addsub_unit (
    .func (req.func),
    .a    (req.a),
    .b    (req.b),
    .cfi  (flags.cf),   // Carry of the operation before, for ADC and SBB
    .res  (arith_res)
  );

  logic_unit u_logic_unit (
    .func (req.func),
    .a    (req.a),
    .b    (req.b),
    .res  (logic_res)
  );

  // Unit code maps straight onto the selector inputs
  mux8 #(
    .payload_t (alu_res_t)
  ) u_res_sel (
    .sel ({1'b0, req.unit}),
    .in0 (conv_res),
    .in1 (arith_res),
    .in2 (logic_res),
    .in3 ('0),           // Unit code 3 gives an empty result
    .in4 ('0),
    .in5 ('0),
    .in6 ('0),
    .in7 ('0),
    .out (sel_res)
  );

  // ========================================
  // Flag register and result register
  // ========================================

  // Each flag takes the new value only where the operation writes it
  assign flags_next = alu_flags_t'((sel_res.flags & sel_res.flags_we) |
                                   (flags & ~sel_res.flags_we));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flags <= '0;
    end else if (flags_wr) begin
      flags <= flags_in;             // Load wins if both strobes arrive together
    end else if (op_valid) begin
      flags <= flags_next;           // Visible to the next operation right away
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      res_valid <= 1'b0;
      res       <= '0;
    end else begin
      res_valid <= op_valid;         // One-cycle pulse per operation
      if (op_valid) begin
        res <= sel_res;              // Held until the next operation
      end
    end
  end

endmodule

// ==== hw/alu_pkg.sv ====
/*
 * ALU shared definitions
 * Unit and function codes, flag layout, request and result records
 */
package alu_pkg;

  // ========================================
  // Unit select and function codes
  // ========================================

  typedef enum logic [1:0] {
    CONV  = 2'd0, // Sign extension and decimal adjust
    ARITH = 2'd1, // Add, subtract and compare
    LOGIC = 2'd2  // Bitwise operations
  } alu_unit_e;

  // Conversion codes keep the classic order, bit 2 picks the word/decimal group
  localparam logic [2:0] CBW = 3'd0;
  localparam logic [2:0] AAA = 3'd1;
  localparam logic [2:0] AAS = 3'd2;
  localparam logic [2:0] CWD = 3'd4;
  localparam logic [2:0] DAA = 3'd5;
  localparam logic [2:0] DAS = 3'd6;

  localparam logic [2:0] ADD = 3'd0;
  localparam logic [2:0] ADC = 3'd1; // Adds CF from the flag register
  localparam logic [2:0] SUB = 3'd2;
  localparam logic [2:0] SBB = 3'd3; // Subtracts CF as a borrow
  localparam logic [2:0] CMP = 3'd4; // Same as SUB, result only feeds flags

  localparam logic [2:0] AND  = 3'd0;
  localparam logic [2:0] OR   = 3'd1;
  localparam logic [2:0] XOR  = 3'd2;
  localparam logic [2:0] NOT  = 3'd3; // Complement of a, leaves flags alone
  localparam logic [2:0] TEST = 3'd4; // AND whose result only feeds flags

  // ========================================
  // Flags and records
  // ========================================

  typedef struct packed {
    logic cf; // Bit 5
    logic pf;
    logic af;
    logic zf;
    logic sf;
    logic of; // Bit 0
  } alu_flags_t;

  typedef logic [5:0] flag_mask_t; // One write enable per flag, same bit order

  localparam flag_mask_t FLAGS_WE_ALL  = 6'b111111;
  localparam flag_mask_t FLAGS_WE_ADJ  = 6'b101001; // cf, af and of
  localparam flag_mask_t FLAGS_WE_NONE = 6'b000000;

  typedef struct packed {
    alu_unit_e   unit;
    logic [2:0]  func;
    logic [15:0] a;   // Also the only operand of the conversion unit
    logic [15:0] b;
  } alu_req_t;

  typedef struct packed {
    logic [31:0] data;     // Upper half carries the CWD extension, zero otherwise
    alu_flags_t  flags;
    flag_mask_t  flags_we;
  } alu_res_t;

  // Zero, sign and parity flags of a 16-bit result, all other flags cleared
  function automatic alu_flags_t szp_flags(input logic [15:0] r);
    alu_flags_t f;
    f    = '0;
    f.pf = ~^r[7:0];        // Parity looks at the low byte only
    f.zf = (r == 16'h0000);
    f.sf = r[15];
    return f;
  endfunction

endpackage

// ==== hw/conv_unit.sv ====
`timescale 1ns/10ps

/*
 * Integer conversion unit
 * CBW and CWD sign extension, AAA, AAS, DAA and DAS adjusts with their flags
 */
module conv_unit
  import alu_pkg::*;
(
  input  logic [2:0]  func,
  input  logic [15:0] x,
  input  logic        afi,  // Current AF from the flag register
  input  logic        cfi,  // Current CF from the flag register
  output alu_res_t    res
);

  logic [15:0] cbw, aaa, aas;
  logic [7:0]  daa_tmp, daa, das_tmp, das;
  logic [15:0] lo_word;   // Selected low half of the result
  logic [15:0] hi_word;   // Upper half, used by CWD only
  logic        acond;     // Low nibble needs adjusting
  logic        dcond;     // High digit of the low byte needs adjusting
  logic        low_cf;
  logic        cfo;

  // ========================================
  // Adjust conditions
  // ========================================

  assign acond  = (x[3:0] > 4'h9) | afi;
  assign dcond  = (x[7:0] > 8'h99) | cfi;
  assign low_cf = (x[7:0] < 8'h06) | cfi; // Low byte would wrap on the 0x06 step

  // ASCII adjust moves the carry into AH and keeps only the low digit in AL
  assign aaa = (acond ? (x + 16'h0106) : x) & 16'hff0f;
  assign aas = (acond ? (x - 16'h0106) : x) & 16'hff0f;

  // Decimal adjust works on AL in two steps, low digit first
  assign daa_tmp = acond ? (x[7:0] + 8'h06) : x[7:0];
  assign daa     = dcond ? (daa_tmp + 8'h60) : daa_tmp;
  assign das_tmp = acond ? (x[7:0] - 8'h06) : x[7:0];
  assign das     = dcond ? (das_tmp - 8'h60) : das_tmp;

  assign cbw = {{8{x[7]}}, x[7:0]};

  // ========================================
  // Result selection
  // ========================================

  mux8 #(
    .payload_t (logic [15:0])
  ) u_word_sel (
    .sel (func),
    .in0 (cbw),
    .in1 (aaa),
    .in2 (aas),
    .in3 (16'h0000),         // Unused code
    .in4 (x),                // CWD leaves AX as it is
    .in5 ({x[15:8], daa}),
    .in6 ({x[15:8], das}),
    .in7 (16'h0000),         // Unused code
    .out (lo_word)
  );

  assign hi_word = (func == CWD) ? {16{x[15]}} : 16'h0000; // DX fill for CWD

  // Decimal adjusts set CF on the high digit, ASCII adjusts on the low one
  assign cfo = func[2] ? (dcond | (acond & low_cf)) : acond;

  always_comb begin
    res          = '0;
    res.data     = {hi_word, lo_word};
    res.flags.cf = cfo;
    res.flags.af = acond;
    res.flags.of = 1'b0;
    case (func)
      AAA, AAS, DAA, DAS: res.flags_we = FLAGS_WE_ADJ;
      default:            res.flags_we = FLAGS_WE_NONE; // Sign extension keeps flags
    endcase
  end

endmodule

// ==== hw/logic_unit.sv ====
`timescale 1ns/10ps

/*
 * Logic unit
 * AND, OR, XOR, NOT and TEST on 16-bit operands
 */
module logic_unit
  import alu_pkg::*;
(
  input  logic [2:0]  func,
  input  logic [15:0] a,
  input  logic [15:0] b,
  output alu_res_t    res
);

  logic [15:0] r;
  logic        writes_flags;

  // ========================================
  // Bitwise operation
  // ========================================

  always_comb begin
    case (func)
      AND, TEST: r = a & b;  // TEST returns the AND too, only its flags matter
      OR:        r = a | b;
      XOR:       r = a ^ b;
      NOT:       r = ~a;     // Single operand
      default:   r = 16'h0000;
    endcase
  end

  // NOT and the unused codes leave the flag register untouched
  assign writes_flags = (func == AND) | (func == OR) | (func == XOR) | (func == TEST);

  // ========================================
  // Result and flags
  // ========================================

  always_comb begin
    res       = '0;
    res.data  = {16'h0000, r};
    res.flags = szp_flags(r);   // cf, af and of come back cleared
    if (writes_flags) begin
      res.flags_we = FLAGS_WE_ALL;
    end else begin
      res.flags_we = FLAGS_WE_NONE;
    end
  end

endmodule

// ==== hw/mux8.sv ====
`timescale 1ns/10ps

/*
 * Eight-way selector
 * Picks one of eight payloads of any packed type
 */
module mux8 #(
  parameter type payload_t = logic [15:0]
) (
  input  logic [2:0] sel,
  input  payload_t   in0,
  input  payload_t   in1,
  input  payload_t   in2,
  input  payload_t   in3,
  input  payload_t   in4,
  input  payload_t   in5,
  input  payload_t   in6,
  input  payload_t   in7,
  output payload_t   out
);

  // One input per select code
  always_comb begin
    case (sel)
      3'd0: out = in0;
      3'd1: out = in1;
      3'd2: out = in2;
      3'd3: out = in3;
      3'd4: out = in4;
      3'd5: out = in5;
      3'd6: out = in6;
      3'd7: out = in7;
    endcase
  end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Builds the ALU testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module alu_core_tb -f compile.f -o alu_sim \
  || { echo "Build FAILED"; exit 1; }

./obj_dir/alu_sim > sim.log 2>&1
cat sim.log

grep -q "tests failed" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "all tests passed" sim.log || { echo "Simulation FAILED, no pass line"; exit 1; }
echo "Simulation PASSED"

// ==== verification/alu_core_assert.sv ====
`timescale 1ns/10ps

/*
 * ALU core protocol assertions
 * Result pulse timing, strobe exclusion and the upper data half
 */
module alu_core_assert
  import alu_pkg::*;
(
  input logic     clk,
  input logic     rst_n,
  input logic     op_valid,
  input logic     flags_wr,
  input alu_req_t req,
  input logic     res_valid,
  input alu_res_t res
);

  // res_valid echoes op_valid exactly one cycle later
  a_valid_rise: assert property (@(posedge clk) disable iff (!rst_n) op_valid |=> res_valid)
    else $error("res_valid missing one cycle after op_valid");

  a_valid_fall: assert property (@(posedge clk) disable iff (!rst_n) !op_valid |=> !res_valid)
    else $error("res_valid high without an operation the cycle before");

  a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n) !(op_valid && flags_wr))
    else $error("flags_wr and op_valid high in the same cycle");

  // Only CWD fills the upper half of the data
  a_upper_zero: assert property (@(posedge clk) disable iff (!rst_n)
    (op_valid && !(req.unit == CONV && req.func == CWD)) |=> (res.data[31:16] == 16'h0000))
    else $error("upper half of res.data set by an operation other than CWD");

endmodule

bind alu_core alu_core_assert u_alu_core_assert (
  .clk       (clk),
  .rst_n     (rst_n),
  .op_valid  (op_valid),
  .flags_wr  (flags_wr),
  .req       (req),
  .res_valid (res_valid),
  .res       (res)
);

// ==== verification/alu_core_tb.sv ====
`timescale 1ns/10ps

/*
 * ALU core testbench
 * Replays the operation trace and checks the results and a reference flag register
 */
module alu_core_tb
  import alu_pkg::*;
();

  // One trace line, fields in file order
  typedef struct packed {
    logic        kind;   // 0 runs an operation, 1 loads the flag register
    logic        chain;  // 1 issues in the cycle right after the line before
    logic [1:0]  unit;
    logic [2:0]  func;
    logic [15:0] a;
    logic [15:0] b;
    logic [31:0] data;   // Expected result data
    logic [5:0]  flags;  // Values of the written flags, or the value to load
  } trace_line_t;

  logic       clk = 1'b0;
  logic       rst_n;
  logic       op_valid;
  alu_req_t   req;
  logic       flags_wr;
  alu_flags_t flags_in;
  logic       res_valid;
  alu_res_t   res;
  alu_flags_t flags;

  trace_line_t trace_q[$];
  logic        trace_loaded = 1'b0;
  alu_flags_t  flag_model;      // Reference copy of the flag register
  int          n_checks = 0;
  int          n_errors = 0;

  alu_core u_alu_core (
    .clk       (clk),
    .rst_n     (rst_n),
    .op_valid  (op_valid),
    .req       (req),
    .flags_wr  (flags_wr),
    .flags_in  (flags_in),
    .res_valid (res_valid),
    .res       (res),
    .flags     (flags)
  );

  always #5 clk = ~clk; // 10 ns period

  // ========================================
  // Checks and reference rules
  // ========================================

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    n_checks++;
    assert (got === expected) else begin
      n_errors++;
      $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, expected);
    end
  endtask

  // Flags that an operation writes, bit order cf pf af zf sf of
  function automatic flag_mask_t write_mask(input logic [1:0] unit, input logic [2:0] func);
    flag_mask_t m;
    m = 6'b000000;
    case (unit)
      CONV:    if (func == AAA || func == AAS || func == DAA || func == DAS) m = 6'b101001;
      ARITH:   if (func <= CMP) m = 6'b111111;
      LOGIC:   if (func <= TEST && func != NOT) m = 6'b111111;
      default: m = 6'b000000;
    endcase
    return m;
  endfunction

  // ========================================
  // Drivers
  // ========================================

  task automatic idle_cycles(input int unsigned n);
    repeat (n) begin
      @(posedge clk);
      #1;
      check_value("res_valid", 32'(res_valid), 32'h0); // No operation, no pulse
    end
  endtask

  task automatic run_op(input trace_line_t t);
    flag_mask_t we;
    we       = write_mask(t.unit, t.func);
    req.unit = alu_unit_e'(t.unit);
    req.func = t.func;
    req.a    = t.a;
    req.b    = t.b;
    op_valid = 1'b1;
    @(posedge clk);
    #1;
    op_valid   = 1'b0;
    flag_model = alu_flags_t'((t.flags & we) | (flag_model & ~we)); // Merge written flags
    check_value("res_valid", 32'(res_valid), 32'h1);
    check_value("res.data", res.data, t.data);
    check_value("res.flags_we", 32'(res.flags_we), 32'(we));
    check_value("res.flags", 32'(res.flags & we), 32'(t.flags & we));
    check_value("flags", 32'(flags), 32'(flag_model));
  endtask

  task automatic load_flags(input trace_line_t t);
    flags_in = alu_flags_t'(t.flags);
    flags_wr = 1'b1;
    @(posedge clk);
    #1;
    flags_wr   = 1'b0;
    flag_model = alu_flags_t'(t.flags);
    check_value("res_valid", 32'(res_valid), 32'h0);
    check_value("flags", 32'(flags), 32'(flag_model));
  endtask

  // ========================================
  // Trace loading
  // ========================================

  initial begin : read_trace
    int          fd;
    int          n;
    string       line;
    logic [31:0] f_kind, f_chain, f_unit, f_func, f_a, f_b, f_data, f_flags;
    trace_line_t t;
    fd = $fopen("verification/alu_trace.txt", "r");
    if (fd == 0) begin
      $display("Could not open the trace file verification/alu_trace.txt");
      $display("tests failed");
      $finish;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 1 && line[0] != "#") begin // Skip comments and blank lines
          n = $sscanf(line, "%h %h %h %h %h %h %h %b",
                      f_kind, f_chain, f_unit, f_func, f_a, f_b, f_data, f_flags);
          if (n == 8) begin
            t.kind  = f_kind[0];
            t.chain = f_chain[0];
            t.unit  = f_unit[1:0];
            t.func  = f_func[2:0];
            t.a     = f_a[15:0];
            t.b     = f_b[15:0];
            t.data  = f_data;
            t.flags = f_flags[5:0];
            trace_q.push_back(t);
          end else begin
            n_errors++;
            $display("Malformed trace line, only %0d fields read: %s", n, line);
          end
        end
      end
      $fclose(fd);
      trace_loaded = 1'b1;
    end
  end

  // ========================================
  // Test sequence
  // ========================================

  initial begin : run_tests
    int unsigned seed;
    int unsigned gap;
    seed     = 32'h383b202e;
    void'($urandom(seed));
    rst_n    = 1'b0;
    op_valid = 1'b0;
    flags_wr = 1'b0;
    req      = '0;
    flags_in = '0;
    flag_model = '0;
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
    // Outputs must come out of reset cleared
    check_value("res_valid", 32'(res_valid), 32'h0);
    check_value("res.data", res.data, 32'h0);
    check_value("res.flags", 32'(res.flags), 32'h0);
    check_value("res.flags_we", 32'(res.flags_we), 32'h0);
    check_value("flags", 32'(flags), 32'h0);
    wait (trace_loaded);
    foreach (trace_q[i]) begin
      if (!trace_q[i].chain) begin
        gap = $urandom % 3;         // Random idle gap between unchained lines
        idle_cycles(gap);
      end
      if (trace_q[i].kind) begin
        load_flags(trace_q[i]);
      end else begin
        run_op(trace_q[i]);
      end
    end
    idle_cycles(2);
    $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // Each line takes at most a few cycles, 20 per line leaves ample slack
  initial begin : watchdog
    int limit_cycles;
    wait (trace_loaded);
    limit_cycles = trace_q.size() * 20 + 16 + 8;
    repeat (limit_cycles) @(posedge clk);
    $display("Timeout, the run did not finish within %0d cycles", limit_cycles);
    $display("tests failed");
    $finish;
  end

endmodule

// ==== verification/alu_trace.txt ====
# kind(0 op, 1 flag load) chain unit func a b exp_data exp_flags(cf pf af zf sf of, binary)
# Ops list the written flags only, loads give the flag value; all fields hex except flags
0 0 0 0 1280 0000 0000FF80 000000
0 1 0 0 347F 0000 0000007F 000000
0 0 0 4 8001 0000 FFFF8001 000000
0 1 0 4 7FFF 0000 00007FFF 000000
1 0 0 0 0000 0000 00000000 000000
0 0 0 1 0009 0000 00000009 000000
0 0 0 1 003A 0000 00000100 101000
1 0 0 0 0000 0000 00000000 001000
0 0 0 1 0105 0000 0000020B 101000
1 0 0 0 0000 0000 00000000 000000
0 0 0 2 020B 0000 00000105 101000
0 1 0 2 0203 0000 0000000D 101000
1 0 0 0 0000 0000 00000000 000000
0 0 0 2 0304 0000 00000304 000000
1 0 0 0 0000 0000 00000000 000000
0 0 0 5 009B 0000 00000001 101000
1 0 0 0 0000 0000 00000000 100000
0 0 0 5 1234 0000 00001294 100000
1 0 0 0 0000 0000 00000000 000000
0 0 0 6 002E 0000 00000028 001000
0 1 0 6 0003 0000 000000FD 101000
0 1 0 6 00A0 0000 0000003A 101000
1 0 0 0 0000 0000 00000000 000000
0 0 1 0 FFFF 0001 00000000 111100
0 1 1 1 0001 0002 00000004 000000
0 0 1 2 0000 0001 0000FFFF 111010
0 1 1 3 0005 0002 00000002 000000
0 0 1 4 0005 0005 00000000 010100
0 0 1 0 0038 0045 0000007D 010000
0 1 0 5 007D 0000 00000083 001000
0 0 1 0 0099 0001 0000009A 010000
0 1 0 5 009A 0000 00000000 101000
1 0 0 0 0000 0000 00000000 111111
0 0 2 0 F0F0 0FF0 000000F0 010000
0 1 2 1 8000 0001 00008001 000010
0 1 2 2 5A5A 5A5A 00000000 010100
1 0 0 0 0000 0000 00000000 111111
0 0 2 3 00FF 0000 0000FF00 000000
0 1 2 4 1234 00C0 00000000 010100
0 1 2 4 8003 FF01 00008001 000010
